/* project.f */
dphy_pkg.sv
csi2_pkg.sv
dphy_byte_align.sv
csi2_ecc_check.sv
csi2_crc16.sv
csi2_packet_handler.sv
csi2_rx_lane.sv
csi2_rx_properties.sv
tb_csi2_rx_lane.sv

/* tb_csi2_rx_lane.sv */
/*
  Testbench for the CSI-2 receive lane
  Serializes table packets at every bit offset into HS bursts and
  checks headers, payload beats and status words against queues
*/
module tb_csi2_rx_lane;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  localparam int ROWS       = 8;
  // Longest burst plus status wait and idle gap in cycles
  localparam int MAX_BURST  = 40;
  localparam int MAX_GAP    = 16;
  localparam int LIMIT_NS   = ( ROWS * ( MAX_BURST + MAX_GAP ) + 20 ) * CLK_PERIOD;

  typedef struct packed {
    logic [5 : 0]  data_type;
    logic [15 : 0] word_count;
    logic [2 : 0]  offset;
    logic          bad_ecc;
    logic          bad_crc;
    logic          exp_ecc_err;
    logic          exp_crc_err;
  } row_t;

  // Type, count, offset, corrupt ECC, corrupt CRC, expected ecc_err, crc_err
  localparam row_t TABLE [ROWS] = '{
    '{ 6'h2A, 16'd6,  3'd0, 1'b0, 1'b0, 1'b0, 1'b0 },
    '{ 6'h00, 16'd1,  3'd1, 1'b0, 1'b0, 1'b0, 1'b0 },
    '{ 6'h1E, 16'd12, 3'd2, 1'b0, 1'b1, 1'b0, 1'b1 },
    '{ 6'h01, 16'd5,  3'd3, 1'b1, 1'b0, 1'b1, 1'b0 },
    '{ 6'h2B, 16'd3,  3'd4, 1'b0, 1'b0, 1'b0, 1'b0 },
    '{ 6'h12, 16'd1,  3'd5, 1'b0, 1'b0, 1'b0, 1'b0 },
    '{ 6'h2C, 16'd9,  3'd6, 1'b1, 1'b0, 1'b1, 1'b0 },
    '{ 6'h24, 16'd16, 3'd7, 1'b0, 1'b0, 1'b0, 1'b0 }
  };

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  dphy_pkg::byte_t         unaligned_byte_i;
  logic                    hs_data_valid_i;
  csi2_pkg::pkt_hdr_t      hdr_o;
  logic                    hdr_valid_o;
  csi2_pkg::payload_beat_t payload_o;
  logic                    payload_valid_o;
  csi2_pkg::pkt_status_t   status_o;
  logic                    status_valid_o;

  // Expected outputs in arrival order
  csi2_pkg::pkt_hdr_t      hdr_q [$];
  csi2_pkg::payload_beat_t beat_q [$];
  csi2_pkg::pkt_status_t   status_q [$];
  csi2_pkg::pkt_hdr_t      exp_hdr;
  csi2_pkg::payload_beat_t exp_beat;
  csi2_pkg::pkt_status_t   exp_status;
  int                      errors = 0;
  int                      checks = 0;
  int                      status_count = 0;

  csi2_rx_lane dut0
  (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .unaligned_byte_i ( unaligned_byte_i ),
    .hs_data_valid_i  ( hs_data_valid_i  ),
    .hdr_o            ( hdr_o            ),
    .hdr_valid_o      ( hdr_valid_o      ),
    .payload_o        ( payload_o        ),
    .payload_valid_o  ( payload_valid_o  ),
    .status_o         ( status_o         ),
    .status_valid_o   ( status_valid_o   )
  );

  bind csi2_packet_handler csi2_rx_properties u_props
  (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .state_i          ( state            ),
    .hdr_valid_i      ( hdr_valid_o      ),
    .payload_valid_i  ( payload_valid_o  ),
    .status_valid_i   ( status_valid_o   ),
    .reset_align_i    ( reset_align_o    )
  );

  always #( CLK_PERIOD / 2 ) clk_i = ~clk_i;

  task automatic check_value( input string name, input logic [31 : 0] expected,
                              input logic [31 : 0] actual );
    checks++;
    if( actual !== expected )
      begin
        errors++;
        $display( "ERROR at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual );
      end
  endtask

  task automatic report_unexpected( input string what );
    errors++;
    $display( "Unexpected %s output at %0d ns with nothing expected", what, $time );
  endtask

  // CSI-2 header parity with one line per ECC bit of the standard table
  function automatic csi2_pkg::ecc_t header_parity( input logic [23 : 0] d );
    csi2_pkg::ecc_t p;
    p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
         ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
         ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
         ^ d[20] ^ d[21] ^ d[22];
    p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
         ^ d[20] ^ d[21] ^ d[23];
    p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
         ^ d[20] ^ d[22] ^ d[23];
    p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
         ^ d[19] ^ d[21] ^ d[22] ^ d[23];
    return p;
  endfunction

  // Bitwise CRC-16 step over one byte taken LSB first
  function automatic csi2_pkg::crc_t crc_fold( input csi2_pkg::crc_t crc,
                                               input dphy_pkg::byte_t b );
    logic fb;
    for( int i = 0; i < 8; i++ )
      begin
        fb  = crc[0] ^ b[i];
        crc = crc >> 1;
        if( fb )
          crc = crc ^ csi2_pkg::CRC_POLY;
      end
    return crc;
  endfunction

  // Build one packet, queue its expected outputs and send it as an HS burst
  task automatic send_row( input row_t row );
    dphy_pkg::byte_t         pkt [$];
    logic                    bits [$];
    csi2_pkg::pkt_hdr_t      hdr;
    csi2_pkg::pkt_status_t   st;
    csi2_pkg::payload_beat_t beat;
    csi2_pkg::crc_t          crc;
    dphy_pkg::byte_t         b;
    logic                    is_long;
    int                      nbytes;
    hdr.data_id    = { 2'( $urandom_range( 3 ) ), row.data_type };
    hdr.word_count = row.word_count;
    hdr.ecc        = header_parity( { hdr.word_count, hdr.data_id } );
    if( row.bad_ecc )
      hdr.ecc[2] = ~hdr.ecc[2];
    is_long = ( row.data_type >= csi2_pkg::LONG_TYPE_MIN );
    // Header goes out ID, count low, count high, ECC
    pkt = '{ hdr.data_id, hdr.word_count[7 : 0], hdr.word_count[15 : 8], { 2'b00, hdr.ecc } };
    hdr_q.push_back( hdr );
    crc = csi2_pkg::CRC_SEED;
    if( is_long )
      begin
        for( int i = 0; i < row.word_count; i++ )
          begin
            // A broken header carries a zero body so no false sync follows it
            b = row.bad_ecc ? 8'h00 : 8'( $urandom_range( 255 ) );
            pkt.push_back( b );
            crc = crc_fold( crc, b );
            beat.data = b;
            beat.last = ( i == row.word_count - 1 );
            if( !row.bad_ecc )
              beat_q.push_back( beat );
          end
        if( row.bad_crc )
          crc[3] = ~crc[3];
        if( row.bad_ecc )
          crc = '0;
        pkt.push_back( crc[7 : 0] );
        pkt.push_back( crc[15 : 8] );
      end
    st.ecc_err = row.exp_ecc_err;
    st.crc_err = row.exp_crc_err;
    st.is_long = is_long;
    st.data_id = hdr.data_id;
    status_q.push_back( st );
    // HS-zero lead-in plus the row's bit offset
    for( int i = 0; i < 8 + row.offset; i++ )
      bits.push_back( 1'b0 );
    for( int i = 0; i < 8; i++ )
      bits.push_back( dphy_pkg::SYNC_PATTERN[i] );
    foreach( pkt[k] )
      for( int i = 0; i < 8; i++ )
        bits.push_back( pkt[k][i] );
    // Zero trailer so the aligner flushes the last packet byte
    nbytes = pkt.size() + 3;
    while( bits.size() < 8 * nbytes )
      bits.push_back( 1'b0 );
    for( int k = 0; k < nbytes; k++ )
      begin
        for( int i = 0; i < 8; i++ )
          b[i] = bits[8 * k + i];
        @( posedge clk_i );
        #1;
        unaligned_byte_i = b;
        hs_data_valid_i  = 1'b1;
      end
    @( posedge clk_i );
    #1;
    hs_data_valid_i  = 1'b0;
    // Garbage on the lane between bursts
    unaligned_byte_i = 8'( $urandom_range( 255 ) );
  endtask

  // Monitor samples at the falling edge where outputs are stable
  always @( negedge clk_i )
    if( !rst_i )
      begin
        if( hdr_valid_o )
          if( hdr_q.size() == 0 )
            report_unexpected( "header" );
          else
            begin
              exp_hdr = hdr_q.pop_front();
              check_value( "hdr_o.data_id", exp_hdr.data_id, hdr_o.data_id );
              check_value( "hdr_o.word_count", exp_hdr.word_count, hdr_o.word_count );
              check_value( "hdr_o.ecc", exp_hdr.ecc, hdr_o.ecc );
            end
        if( payload_valid_o )
          if( beat_q.size() == 0 )
            report_unexpected( "payload" );
          else
            begin
              exp_beat = beat_q.pop_front();
              check_value( "payload_o.data", exp_beat.data, payload_o.data );
              check_value( "payload_o.last", exp_beat.last, payload_o.last );
            end
        if( status_valid_o )
          begin
            status_count++;
            if( status_q.size() == 0 )
              report_unexpected( "status" );
            else
              begin
                exp_status = status_q.pop_front();
                check_value( "status_o.ecc_err", exp_status.ecc_err, status_o.ecc_err );
                check_value( "status_o.crc_err", exp_status.crc_err, status_o.crc_err );
                check_value( "status_o.is_long", exp_status.is_long, status_o.is_long );
                check_value( "status_o.data_id", exp_status.data_id, status_o.data_id );
              end
          end
      end

  // Watchdog sized from the table length
  initial
    begin
      #( LIMIT_NS );
      $display( "Timeout after %0d ns, the lane stopped delivering status words", LIMIT_NS );
      $display( "Checks failed" );
      $finish;
    end

  initial
    begin
      void'( $urandom( 35012 ) );
      rst_i            = 1'b1;
      unaligned_byte_i = '0;
      hs_data_valid_i  = 1'b0;
      repeat( 2 ) @( posedge clk_i );
      #1;
      rst_i = 1'b0;
      for( int r = 0; r < ROWS; r++ )
        begin
          send_row( TABLE[r] );
          // Each burst ends in exactly one status
          wait( status_count == r + 1 );
          repeat( $urandom_range( 2, 8 ) ) @( posedge clk_i );
        end
      repeat( 10 ) @( posedge clk_i );
      check_value( "status count", ROWS, status_count );
      if( hdr_q.size() != 0 || beat_q.size() != 0 || status_q.size() != 0 )
        begin
          errors++;
          $display( "Some expected outputs never appeared: %0d headers, %0d beats, %0d status",
                    hdr_q.size(), beat_q.size(), status_q.size() );
        end
      errors += dut0.u_handler.u_props.fail_count;
      $display( "Checks run: %0d, errors: %0d", checks, errors );
      if( errors == 0 )
        $display( "All checks passed" );
      else
        $display( "Checks failed" );
      $finish;
    end

endmodule

/* csi2_rx_properties.sv */
/*
  Assertions on the packet handler strobes and state
  Bound into the packet handler from the testbench
*/
module csi2_rx_properties
(
  input logic                 clk_i,
  input logic                 rst_i,
  input csi2_pkg::pkt_state_t state_i,
  input logic                 hdr_valid_i,
  input logic                 payload_valid_i,
  input logic                 status_valid_i,
  input logic                 reset_align_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failing assertions so far
  int fail_count = 0;

  // Header strobe lasts a single cycle
  hdr_pulse: assert property ( @( posedge clk_i ) disable iff ( rst_i )
                               hdr_valid_i |=> !hdr_valid_i )
    else
      begin
        $error( "hdr_valid_o stayed high for more than one cycle" );
        fail_count++;
      end

  // One status strobe per packet
  status_pulse: assert property ( @( posedge clk_i ) disable iff ( rst_i )
                                  status_valid_i |=> !status_valid_i )
    else
      begin
        $error( "status_valid_o stayed high for more than one cycle" );
        fail_count++;
      end

  // Aligner release is a single pulse as well
  align_pulse: assert property ( @( posedge clk_i ) disable iff ( rst_i )
                                 reset_align_i |=> !reset_align_i )
    else
      begin
        $error( "reset_align_o stayed high for more than one cycle" );
        fail_count++;
      end

  // Resync goes out together with every status
  align_with_status: assert property ( @( posedge clk_i ) disable iff ( rst_i )
                                       reset_align_i == status_valid_i )
    else
      begin
        $error( "reset_align_o and status_valid_o differ" );
        fail_count++;
      end

  // Payload only while a packet is open
  no_idle_payload: assert property ( @( posedge clk_i ) disable iff ( rst_i )
                                     !( payload_valid_i && state_i == csi2_pkg::ST_IDLE ) )
    else
      begin
        $error( "payload_valid_o high while the handler is idle" );
        fail_count++;
      end

endmodule

/* csi2_rx_lane.sv */
/*
  Receive path of one D-PHY data lane into the CSI-2 packet layer
  Aligner output feeds the packet handler, which uses the ECC and
  CRC units and releases the aligner lock at the end of each packet
*/
module csi2_rx_lane
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  dphy_pkg::byte_t         unaligned_byte_i,
  input  logic                    hs_data_valid_i,
  output csi2_pkg::pkt_hdr_t      hdr_o,
  output logic                    hdr_valid_o,
  output csi2_pkg::payload_beat_t payload_o,
  output logic                    payload_valid_o,
  output csi2_pkg::pkt_status_t   status_o,
  output logic                    status_valid_o
);

dphy_pkg::byte_t aligned_byte;
logic            aligned_valid;
logic            reset_align;
logic [23 : 0]   hdr_bits;
csi2_pkg::ecc_t  hdr_ecc;
logic            ecc_err;
logic            crc_clear;
logic            crc_en;
csi2_pkg::crc_t  crc_value;

dphy_byte_align u_align
(
  .clk_i            ( clk_i            ),
  .rst_i            ( rst_i            ),
  .unaligned_byte_i ( unaligned_byte_i ),
  .reset_align_i    ( reset_align      ),
  .hs_data_valid_i  ( hs_data_valid_i  ),
  .valid_o          ( aligned_valid    ),
  .aligned_byte_o   ( aligned_byte     )
);

csi2_packet_handler u_handler
(
  .clk_i            ( clk_i            ),
  .rst_i            ( rst_i            ),
  .byte_i           ( aligned_byte     ),
  .byte_valid_i     ( aligned_valid    ),
  .ecc_err_i        ( ecc_err          ),
  .crc_i            ( crc_value        ),
  .hdr_bits_o       ( hdr_bits         ),
  .ecc_o            ( hdr_ecc          ),
  .crc_clear_o      ( crc_clear        ),
  .crc_en_o         ( crc_en           ),
  .reset_align_o    ( reset_align      ),
  .hdr_o            ( hdr_o            ),
  .hdr_valid_o      ( hdr_valid_o      ),
  .payload_o        ( payload_o        ),
  .payload_valid_o  ( payload_valid_o  ),
  .status_o         ( status_o         ),
  .status_valid_o   ( status_valid_o   )
);

// Combinational header check
csi2_ecc_check u_ecc
(
  .data_i           ( hdr_bits         ),
  .ecc_i            ( hdr_ecc          ),
  .ecc_err_o        ( ecc_err          )
);

// Payload checksum, fed straight from the aligned stream
csi2_crc16 u_crc
(
  .clk_i            ( clk_i            ),
  .rst_i            ( rst_i            ),
  .clear_i          ( crc_clear        ),
  .en_i             ( crc_en           ),
  .byte_i           ( aligned_byte     ),
  .crc_o            ( crc_value        )
);

endmodule

/* csi2_packet_handler.sv */
/*
  CSI-2 packet handler for one aligned byte stream
  Collects the header, forwards long packet payload, checks the CRC
  and reports one status per packet while resetting the aligner
*/
module csi2_packet_handler
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  dphy_pkg::byte_t         byte_i,
  input  logic                    byte_valid_i,
  input  logic                    ecc_err_i,
  input  csi2_pkg::crc_t          crc_i,
  output logic [23 : 0]           hdr_bits_o,
  output csi2_pkg::ecc_t          ecc_o,
  output logic                    crc_clear_o,
  output logic                    crc_en_o,
  output logic                    reset_align_o,
  output csi2_pkg::pkt_hdr_t      hdr_o,
  output logic                    hdr_valid_o,
  output csi2_pkg::payload_beat_t payload_o,
  output logic                    payload_valid_o,
  output csi2_pkg::pkt_status_t   status_o,
  output logic                    status_valid_o
);

csi2_pkg::pkt_state_t  state;
// Header bytes 0..2 while the ECC byte is used straight from the input
dphy_pkg::byte_t       hdr_buf [3];
logic [1 : 0]          byte_cnt;
csi2_pkg::word_count_t remaining;
logic                  crc_lo_ok;
csi2_pkg::data_id_t    cur_id;
csi2_pkg::word_count_t cur_wc;
logic                  cur_long;
logic                  hdr_last;
logic                  crc_last;

assign cur_id   = hdr_buf[0];
// Word count arrives low byte first
assign cur_wc   = { hdr_buf[2], hdr_buf[1] };
assign cur_long = ( cur_id[5 : 0] >= csi2_pkg::LONG_TYPE_MIN );

// ECC byte in flight while the data bits sit in the buffer
assign hdr_last = byte_valid_i && ( state == csi2_pkg::ST_HEADER ) && ( byte_cnt == 2'd3 );
// Second CRC byte in flight
assign crc_last = byte_valid_i && ( state == csi2_pkg::ST_CRC ) && ( byte_cnt == 2'd1 );

// Checker inputs
assign hdr_bits_o = { cur_wc, cur_id };
assign ecc_o      = byte_i[5 : 0];

// CRC is reseeded during the header and fed with payload only
assign crc_clear_o = ( state == csi2_pkg::ST_HEADER );
assign crc_en_o    = byte_valid_i && ( state == csi2_pkg::ST_PAYLOAD );

// Aligner resync together with every status
assign reset_align_o = status_valid_o;

// Packet FSM
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      state           <= csi2_pkg::ST_IDLE;
      byte_cnt        <= '0;
      remaining       <= '0;
      hdr_valid_o     <= 1'b0;
      payload_valid_o <= 1'b0;
      status_valid_o  <= 1'b0;
    end
  else
    begin
      hdr_valid_o     <= 1'b0;
      payload_valid_o <= 1'b0;
      status_valid_o  <= 1'b0;
      // Lane lost mid-packet drops the packet silently
      if( !byte_valid_i )
        state <= csi2_pkg::ST_IDLE;
      else
        case( state )
          csi2_pkg::ST_IDLE:
            // Trailing byte during resync is not a new header
            if( !reset_align_o )
              begin
                state    <= csi2_pkg::ST_HEADER;
                byte_cnt <= 2'd1;
              end
          csi2_pkg::ST_HEADER:
            begin
              byte_cnt <= byte_cnt + 2'd1;
              if( hdr_last )
                begin
                  hdr_valid_o <= 1'b1;
                  // Bad header or short packet ends here
                  if( ecc_err_i || !cur_long )
                    begin
                      status_valid_o <= 1'b1;
                      state          <= csi2_pkg::ST_IDLE;
                    end
                  else
                    if( cur_wc == '0 )
                      begin
                        state    <= csi2_pkg::ST_CRC;
                        byte_cnt <= '0;
                      end
                    else
                      begin
                        state     <= csi2_pkg::ST_PAYLOAD;
                        remaining <= cur_wc;
                      end
                end
            end
          csi2_pkg::ST_PAYLOAD:
            begin
              payload_valid_o <= 1'b1;
              remaining       <= remaining - 1'b1;
              if( remaining == 16'd1 )
                begin
                  state    <= csi2_pkg::ST_CRC;
                  byte_cnt <= '0;
                end
            end
          csi2_pkg::ST_CRC:
            begin
              byte_cnt <= byte_cnt + 2'd1;
              if( crc_last )
                begin
                  status_valid_o <= 1'b1;
                  state          <= csi2_pkg::ST_IDLE;
                end
            end
          default:
            state <= csi2_pkg::ST_IDLE;
        endcase
    end

// Data registers that are meaningful only under their valids
always_ff @( posedge clk_i )
  if( byte_valid_i )
    case( state )
      csi2_pkg::ST_IDLE:
        hdr_buf[0] <= byte_i;
      csi2_pkg::ST_HEADER:
        if( hdr_last )
          begin
            hdr_o.data_id    <= cur_id;
            hdr_o.word_count <= cur_wc;
            hdr_o.ecc        <= byte_i[5 : 0];
            status_o.ecc_err <= ecc_err_i;
            status_o.crc_err <= 1'b0;
            status_o.is_long <= cur_long;
            status_o.data_id <= cur_id;
          end
        else
          hdr_buf[byte_cnt] <= byte_i;
      csi2_pkg::ST_PAYLOAD:
        begin
          payload_o.data <= byte_i;
          payload_o.last <= ( remaining == 16'd1 );
        end
      csi2_pkg::ST_CRC:
        // Received CRC comes low byte first and crc_i is final by now
        if( crc_last )
          status_o.crc_err <= !( crc_lo_ok && ( byte_i == crc_i[15 : 8] ) );
        else
          crc_lo_ok <= ( byte_i == crc_i[7 : 0] );
    endcase

endmodule

/* csi2_crc16.sv */
/*
  Running CRC-16 for CSI-2 long packet payload
  Folds one byte per enabled cycle, LSB first, reflected polynomial
  Clear reloads the seed before the first payload byte
*/
module csi2_crc16
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            clear_i,
  input  logic            en_i,
  input  dphy_pkg::byte_t byte_i,
  output csi2_pkg::crc_t  crc_o
);

csi2_pkg::crc_t crc_next;

// Bit-serial update unrolled over the eight bits of the byte
always_comb
  begin
    crc_next = crc_o;
    for( int b = 0; b < 8; b++ )
      if( crc_next[0] ^ byte_i[b] )
        crc_next = ( crc_next >> 1 ) ^ csi2_pkg::CRC_POLY;
      else
        crc_next = crc_next >> 1;
  end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    crc_o <= csi2_pkg::CRC_SEED;
  else
    // Clear wins over a byte in the same cycle
    if( clear_i )
      crc_o <= csi2_pkg::CRC_SEED;
    else
      if( en_i )
        crc_o <= crc_next;

endmodule

/* csi2_ecc_check.sv */
/*
  CSI-2 packet header ECC check
  Recomputes the 6-bit Hamming parity over the 24 header data bits
  and flags any difference from the received value, no correction
*/
module csi2_ecc_check
(
  input  logic [23 : 0]   data_i,
  input  csi2_pkg::ecc_t  ecc_i,
  output logic            ecc_err_o
);

// data_i is {word_count, data_id}, bit 0 is data_id bit 0
csi2_pkg::ecc_t ecc_calc;

// Each parity bit is the XOR of the bits selected by its mask
always_comb
  for( int p = 0; p < 6; p++ )
    ecc_calc[p] = ^( data_i & csi2_pkg::ECC_MASK[p] );

// Upper two bits of the ECC byte never reach this block
// Any single mismatch is an error
assign ecc_err_o = ( ecc_calc != ecc_i );

endmodule

/* dphy_byte_align.sv */
/*
  Byte aligner for one HS data lane
  Searches the unaligned byte stream for the leader sync byte,
  locks the bit offset and then outputs bytes shifted by it
  until the packet layer or the end of the burst releases the lock
*/
module dphy_byte_align
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  dphy_pkg::byte_t unaligned_byte_i,
  input  logic            reset_align_i,
  input  logic            hs_data_valid_i,
  output logic            valid_o,
  output dphy_pkg::byte_t aligned_byte_o
);

// Window layout, LSB first on the wire
// | byte_d1 (newer)             | byte_d2 (older)             |
// |      ... sync byte starts at bit sync_offset of byte_d2   |

dphy_pkg::byte_t  byte_d1;
dphy_pkg::byte_t  byte_d2;
logic             hs_d1;
logic             hs_d2;
logic [15 : 0]    window;
logic             win_valid;
dphy_pkg::shift_t sync_offset;
logic             found_sync;
dphy_pkg::shift_t align_shift;
logic             sync_done;

// Two byte delay stages of the raw stream
always_ff @( posedge clk_i )
  begin
    byte_d1 <= unaligned_byte_i;
    byte_d2 <= byte_d1;
  end

// HS valid travels alongside the bytes it qualifies
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      hs_d1 <= 1'b0;
      hs_d2 <= 1'b0;
    end
  else
    begin
      hs_d1 <= hs_data_valid_i;
      hs_d2 <= hs_d1;
    end

assign window    = { byte_d1, byte_d2 };
// Search only when both window bytes belong to the burst
assign win_valid = hs_d1 && hs_d2;

// Offset search over all eight positions
// Loop runs downwards so the lowest matching offset wins
always_comb
  begin
    sync_offset = '0;
    found_sync  = 1'b0;
    if( win_valid )
      for( int i = 7; i >= 0; i-- )
        if( window[i +: 8] == dphy_pkg::SYNC_PATTERN )
          begin
            sync_offset = dphy_pkg::shift_t'( i );
            found_sync  = 1'b1;
          end
  end

// Lock the offset on the first hit of a burst
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      align_shift <= '0;
      sync_done   <= 1'b0;
    end
  else
    // Packet end or burst end releases the lock
    if( reset_align_i || !hs_d1 )
      sync_done <= 1'b0;
    else
      if( !sync_done && found_sync )
        begin
          align_shift <= sync_offset;
          sync_done   <= 1'b1;
        end

// Bytes are valid from the one after the sync byte onwards
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    valid_o <= 1'b0;
  else
    valid_o <= sync_done && hs_d1 && !reset_align_i;

// Output byte taken from the window at the locked offset
always_ff @( posedge clk_i )
  aligned_byte_o <= window[align_shift +: 8];

endmodule

/* csi2_pkg.sv */
/*
  CSI-2 packet layer definitions
  Header, status and payload beat structs, checksum constants,
  ECC parity masks and the packet handler state encoding
*/
package csi2_pkg;

  // Virtual channel in [7:6], data type in [5:0]
  typedef logic [7 : 0]  data_id_t;
  typedef logic [15 : 0] word_count_t;
  typedef logic [5 : 0]  ecc_t;
  typedef logic [15 : 0] crc_t;

  // Data types from this value up are long packets
  localparam logic [5 : 0] LONG_TYPE_MIN = 6'h10;

  // CRC-16 with reflected polynomial, bytes folded in LSB first
  localparam crc_t CRC_SEED = 16'hFFFF;
  localparam crc_t CRC_POLY = 16'h8408;

  // Header parity masks over {word_count, data_id}
  // Entry p selects the data bits XORed into ECC bit p
  localparam logic [5 : 0][23 : 0] ECC_MASK = { 24'hEFFC00, 24'hDF03F0, 24'hB8E38E,
                                               24'h749A6D, 24'hF2555B, 24'hF12CB7 };

  typedef struct packed {
    data_id_t    data_id;
    word_count_t word_count;
    ecc_t        ecc;
  } pkt_hdr_t;

  typedef struct packed {
    logic     ecc_err;
    logic     crc_err;
    logic     is_long;
    data_id_t data_id;
  } pkt_status_t;

  typedef struct packed {
    dphy_pkg::byte_t data;
    logic            last;
  } payload_beat_t;

  typedef enum logic [1 : 0] {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD,
    ST_CRC
  } pkt_state_t;

endpackage

/* dphy_pkg.sv */
/*
  PHY-level definitions for one D-PHY data lane
  Byte type, bit-offset type and the leader sync byte
  used by the aligner when searching the HS stream
*/
package dphy_pkg;

  // One deserialized lane byte
  typedef logic [7 : 0] byte_t;

  // Bit offset of the sync byte inside the two-byte window
  // Only 0 to 7 are used
  typedef logic [3 : 0] shift_t;

  // Leader byte of every HS burst sent LSB first on the wire
  localparam byte_t SYNC_PATTERN = 8'b1011_1000;

endpackage
